// File: src/stream_pkg.sv
// stream beat layout shared by the FIFO, the limiter and the counters
// widths for data, keep and user sideband
`default_nettype none

package stream_pkg;

    // payload width in bits
    localparam int data_width = 32;

    // one keep bit per byte lane
    localparam int keep_width = data_width / 8;

    // user sideband, passed through untouched
    localparam int user_width = 1;

    // enough bits to hold a popcount of keep (0 to keep_width)
    localparam int keep_count_width = $clog2(keep_width + 1);

    // one beat on the stream, 38 bits at the default widths
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [keep_width-1:0] keep;
        logic                  last;
        logic [user_width-1:0] user;
    } stream_beat_t;

endpackage

`default_nettype wire

// File: src/rate_pkg.sv
// rate limiter configuration struct, accumulator width, frame tracking enum
`default_nettype none

package rate_pkg;

    // credit accumulator width
    localparam int acc_width = 24;

    // average throughput is num/denom beats per cycle
    // only meaningful for 0 < num <= denom
    typedef struct packed {
        logic [7:0] num;
        logic [7:0] denom;
        // hold pauses until a frame boundary
        logic       by_frame;
    } rate_cfg_t;

    // did the last accepted beat close a frame
    typedef enum logic {
        between_frames,
        in_frame
    } frame_state_e;

endpackage

`default_nettype wire

// File: src/stream_fifo.sv
// synchronous FIFO of stream beats, valid/ready on both sides
// registered output stage with bypass when the buffer is empty
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int fifo_depth_log2 = 4
) (
    input  logic                     clk,
    input  logic                     rst,

    input  stream_pkg::stream_beat_t s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,

    output stream_pkg::stream_beat_t m_beat,
    output logic                     m_valid,
    input  logic                     m_ready
);
    import stream_pkg::*;

    // storage, no reset on the payload
    stream_beat_t mem [1 << fifo_depth_log2];

    // pointers carry one extra wrap bit
    logic [fifo_depth_log2:0] wr_ptr;
    logic [fifo_depth_log2:0] rd_ptr;
    logic [fifo_depth_log2:0] wr_ptr_next;
    logic [fifo_depth_log2:0] rd_ptr_next;

    logic         empty;
    logic         full_next;
    logic         push;
    logic         out_load;
    logic         bypass;
    logic         pop;

    stream_beat_t out_beat_reg;
    logic         out_valid_reg;
    logic         s_ready_reg;

    assign s_ready = s_ready_reg;
    assign m_beat  = out_beat_reg;
    assign m_valid = out_valid_reg;

    assign empty = (wr_ptr == rd_ptr);

    // input handshake
    assign push = s_valid && s_ready_reg;

    // output register free this cycle
    assign out_load = !out_valid_reg || m_ready;

    // empty buffer, so the beat goes straight to the output register
    assign bypass = push && empty && out_load;

    // refill output from storage
    assign pop = out_load && !empty;

    always_comb begin
        wr_ptr_next = wr_ptr;
        rd_ptr_next = rd_ptr;
        if (push && !bypass) begin
            wr_ptr_next = wr_ptr + (fifo_depth_log2 + 1)'(1);
        end
        if (pop) begin
            rd_ptr_next = rd_ptr + (fifo_depth_log2 + 1)'(1);
        end
        // full when the wrap bits differ and the addresses match
        full_next = (wr_ptr_next[fifo_depth_log2] != rd_ptr_next[fifo_depth_log2]) &&
                    (wr_ptr_next[fifo_depth_log2-1:0] == rd_ptr_next[fifo_depth_log2-1:0]);
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            out_valid_reg <= 1'b0;
            s_ready_reg   <= 1'b0;
        end else begin
            wr_ptr      <= wr_ptr_next;
            rd_ptr      <= rd_ptr_next;
            // ready follows the pointers of the next cycle
            s_ready_reg <= !full_next;
            if (out_load) begin
                out_valid_reg <= !empty || push;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (push && !bypass) begin
            mem[wr_ptr[fifo_depth_log2-1:0]] <= s_beat;
        end
        if (pop) begin
            out_beat_reg <= mem[rd_ptr[fifo_depth_log2-1:0]];
        end else if (bypass) begin
            out_beat_reg <= s_beat;
        end
    end

endmodule

`default_nettype wire

// File: src/rate_limiter.sv
// credit-accumulator rate limiter for a beat stream
// optional frame-boundary pausing, two-register skid stage on the output
`timescale 1ns/1ps
`default_nettype none

module rate_limiter (
    input  logic                     clk,
    input  logic                     rst,

    input  rate_pkg::rate_cfg_t      cfg,

    input  stream_pkg::stream_beat_t s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,

    output stream_pkg::stream_beat_t m_beat,
    output logic                     m_valid,
    input  logic                     m_ready
);
    import stream_pkg::*;
    import rate_pkg::*;

    // credit state
    logic [acc_width-1:0] acc_reg;
    logic [acc_width-1:0] acc_next;
    logic [acc_width-1:0] num_ext;
    logic [acc_width-1:0] step;
    frame_state_e         frame_state;
    frame_state_e         frame_state_next;
    logic                 pause;

    // input handshake
    logic                 s_ready_reg;
    logic                 s_ready_next;
    logic                 accept;

    // skid stage can take a beat next cycle
    logic                 int_ready_early;
    logic                 int_ready_reg;

    // main output register
    stream_beat_t         out_beat_reg;
    logic                 out_valid_reg;
    logic                 out_valid_next;

    // temporary register, holds one beat while the sink stalls
    stream_beat_t         temp_beat_reg;
    logic                 temp_valid_reg;
    logic                 temp_valid_next;

    // datapath steering
    logic                 store_int_to_out;
    logic                 store_int_to_temp;
    logic                 store_temp_to_out;

    assign s_ready = s_ready_reg;
    assign m_beat  = out_beat_reg;
    assign m_valid = out_valid_reg;

    assign accept  = s_valid && s_ready_reg;

    // num and the per-beat credit step at accumulator width
    assign num_ext = acc_width'(cfg.num);
    assign step    = acc_width'(cfg.denom) - num_ext;

    always_comb begin
        acc_next         = acc_reg;
        frame_state_next = frame_state;
        pause            = 1'b0;

        // idle cycles drain num credits
        if (acc_reg >= num_ext) begin
            acc_next = acc_reg - num_ext;
        end

        // an accepted beat costs denom - num
        if (accept) begin
            acc_next         = acc_reg + step;
            frame_state_next = s_beat.last ? between_frames : in_frame;
        end

        // still in debt, so hold off
        if (acc_next >= num_ext) begin
            if (cfg.by_frame) begin
                // never stall in the middle of a frame
                pause = (frame_state_next == between_frames);
            end else begin
                pause = 1'b1;
            end
        end

        s_ready_next = int_ready_early && !pause;
    end

    // ready next cycle if the sink takes data, or the temp reg stays empty
    assign int_ready_early = m_ready ||
                             (!temp_valid_reg && (!out_valid_reg || !accept));

    always_comb begin
        out_valid_next    = out_valid_reg;
        temp_valid_next   = temp_valid_reg;
        store_int_to_out  = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (int_ready_reg) begin
            if (m_ready || !out_valid_reg) begin
                // output free, load it directly
                out_valid_next   = accept;
                store_int_to_out = 1'b1;
            end else begin
                // sink stalled, park the beat
                temp_valid_next   = accept;
                store_int_to_temp = 1'b1;
            end
        end else if (m_ready) begin
            // input closed, drain temp into the output
            out_valid_next    = temp_valid_reg;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_reg        <= '0;
            frame_state    <= between_frames;
            s_ready_reg    <= 1'b0;
            int_ready_reg  <= 1'b0;
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
        end else begin
            acc_reg        <= acc_next;
            frame_state    <= frame_state_next;
            s_ready_reg    <= s_ready_next;
            int_ready_reg  <= int_ready_early;
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            out_beat_reg <= s_beat;
        end else if (store_temp_to_out) begin
            out_beat_reg <= temp_beat_reg;
        end
        if (store_int_to_temp) begin
            temp_beat_reg <= s_beat;
        end
    end

endmodule

`default_nettype wire

// File: src/stream_stats.sv
// frame and byte counters for a monitored stream
// counts only beats that complete a valid/ready handshake
`timescale 1ns/1ps
`default_nettype none

module stream_stats (
    input  logic                     clk,
    input  logic                     rst,

    // observed stream, no ready driven back
    input  stream_pkg::stream_beat_t beat,
    input  logic                     valid,
    input  logic                     ready,

    output logic [31:0]              frame_count,
    output logic [31:0]              byte_count
);
    import stream_pkg::*;

    logic                        fire;
    logic [keep_count_width-1:0] keep_ones;

    assign fire = valid && ready;

    // popcount of the keep lanes
    always_comb begin
        keep_ones = '0;
        for (int i = 0; i < keep_width; i++) begin
            keep_ones = keep_ones + keep_count_width'(beat.keep[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_count <= '0;
            byte_count  <= '0;
        end else if (fire) begin
            byte_count <= byte_count + 32'(keep_ones);
            // one frame per last beat
            if (beat.last) begin
                frame_count <= frame_count + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/rate_limited_port.sv
// rate-limited egress port
// FIFO buffer, credit rate limiter and output statistics
`timescale 1ns/1ps
`default_nettype none

module rate_limited_port (
    input  logic                     clk,
    input  logic                     rst,

    // static while traffic flows
    input  rate_pkg::rate_cfg_t      cfg,

    input  stream_pkg::stream_beat_t s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,

    output stream_pkg::stream_beat_t m_beat,
    output logic                     m_valid,
    input  logic                     m_ready,

    output logic [31:0]              frame_count,
    output logic [31:0]              byte_count
);
    import stream_pkg::*;

    // FIFO to limiter
    stream_beat_t fifo_beat;
    logic         fifo_valid;
    logic         limiter_ready;

    stream_fifo fifo_i (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (fifo_beat),
        .m_valid (fifo_valid),
        .m_ready (limiter_ready)
    );

    rate_limiter limiter_i (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg),
        .s_beat  (fifo_beat),
        .s_valid (fifo_valid),
        .s_ready (limiter_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    // watches the shaped output only
    stream_stats stats_i (
        .clk         (clk),
        .rst         (rst),
        .beat        (m_beat),
        .valid       (m_valid),
        .ready       (m_ready),
        .frame_count (frame_count),
        .byte_count  (byte_count)
    );

endmodule

`default_nettype wire

// File: test/tb_checks.svh
// compare tasks for stream beats, counters and single flags
// xorshift generator for the random stimulus
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// 32-bit xorshift, 13/17/5 shifts
function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// one output beat against its reference, field by field
task automatic check_beat(input stream_beat_t got, input stream_beat_t exp);
    if (got.data !== exp.data) begin
        report_failure($sformatf("mismatch at time %0t: beat data expected %h got %h",
                                 $time, exp.data, got.data));
    end else if (got.keep !== exp.keep) begin
        report_failure($sformatf("mismatch at time %0t: beat keep expected %b got %b",
                                 $time, exp.keep, got.keep));
    end else if (got.last !== exp.last) begin
        report_failure($sformatf("mismatch at time %0t: beat last expected %b got %b",
                                 $time, exp.last, got.last));
    end else if (got.user !== exp.user) begin
        report_failure($sformatf("mismatch at time %0t: beat user expected %b got %b",
                                 $time, exp.user, got.user));
    end
endtask

// a single 32-bit counter
task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        report_failure($sformatf("mismatch at time %0t: %s expected %0d got %0d",
                                 $time, name, exp, got));
    end
endtask

// both statistics counters
task automatic check_counts(input logic [31:0] frames_got, input logic [31:0] bytes_got,
                            input logic [31:0] frames_exp, input logic [31:0] bytes_exp);
    check_count("frame_count", frames_got, frames_exp);
    check_count("byte_count", bytes_got, bytes_exp);
endtask

// handshake flags
task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        report_failure($sformatf("mismatch at time %0t: %s expected %b got %b",
                                 $time, name, exp, got));
    end
endtask

`endif

// File: test/tb_rate_limited_port.sv
// testbench for the rate-limited egress port
// xorshift frame source, sink back-pressure, reference beats and counters
// rate window and frame burst checks, cycle timeout
`timescale 1ns/1ps
`default_nettype none

module tb_rate_limited_port;
    import stream_pkg::*;
    import rate_pkg::*;

    logic         clk;
    logic         rst;
    rate_cfg_t    cfg;
    stream_beat_t s_beat;
    logic         s_valid;
    logic         s_ready;
    stream_beat_t m_beat;
    logic         m_valid;
    logic         m_ready;
    logic [31:0]  frame_count;
    logic [31:0]  byte_count;

    // beats still to send, beats still to see
    stream_beat_t drive_q[$];
    stream_beat_t exp_q[$];
    stream_beat_t exp_beat;
    // cycle numbers of output transfers, for the rate window
    int           out_cycles[$];

    logic [31:0]  rng_state;
    bit           ready_random;
    bit           window_check;
    bit           burst_check;
    bit           in_burst;
    int           cycle_count;
    int           deadline;

    rate_limited_port dut_i (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .m_beat      (m_beat),
        .m_valid     (m_valid),
        .m_ready     (m_ready),
        .frame_count (frame_count),
        .byte_count  (byte_count)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tb_checks.svh"

    function automatic rate_cfg_t make_cfg(input int num, input int denom, input bit by_frame);
        rate_cfg_t c;
        c.num      = 8'(num);
        c.denom    = 8'(denom);
        c.by_frame = by_frame;
        return c;
    endfunction

    // reference beat idx of a frame: full keep except on the last beat
    function automatic stream_beat_t ref_beat(input logic [31:0] seed, input int len,
                                              input int idx);
        logic [31:0]  h;
        stream_beat_t b;
        h      = xorshift(seed ^ (32'(idx + 1) << 24));
        b.data = h;
        b.last = (idx == len - 1);
        // last beat keeps at least one byte
        b.keep = b.last ? (keep_width'(xorshift(h)) | keep_width'(1)) : '1;
        b.user = ^h;
        return b;
    endfunction

    function automatic int keep_bytes(input logic [keep_width-1:0] k);
        int n;
        n = 0;
        for (int i = 0; i < keep_width; i++) begin
            n += int'(k[i]);
        end
        return n;
    endfunction

    always #10 clk = ~clk;

    // source, valid whenever beats are queued
    always @(posedge clk) begin
        // the first reset edge still sees the old ready
        if (!rst && s_valid && s_ready) begin
            void'(drive_q.pop_front());
        end
        #2;
        if (drive_q.size() != 0) begin
            s_valid = 1'b1;
            s_beat  = drive_q[0];
        end else begin
            s_valid = 1'b0;
            s_beat  = '0;
        end
    end

    // sink, always ready or about half the cycles
    always @(posedge clk) begin
        #2;
        if (ready_random) begin
            rng_state = xorshift(rng_state);
            m_ready   = rng_state[4];
        end else begin
            m_ready = 1'b1;
        end
    end

    // cycle counter, timeout and output compare
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= deadline) begin
            report_failure($sformatf("timeout after %0d cycles, output never drained",
                                     cycle_count));
        end
        if (rst) begin
            in_burst = 1'b0;
        end else begin
            // frame mode keeps a frame together on the wire
            if (burst_check && in_burst && m_ready && !m_valid) begin
                report_failure($sformatf("output went idle inside a frame at time %0t", $time));
            end
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("output beat arrived with no beat left to expect");
                end else begin
                    exp_beat = exp_q.pop_front();
                    check_beat(m_beat, exp_beat);
                    if (window_check) begin
                        out_cycles.push_back(cycle_count);
                    end
                    in_burst = !m_beat.last;
                end
            end
        end
    end

    // every window may carry num/denom of its cycles plus two
    task automatic check_window();
        int span;
        int limit;
        for (int i = 0; i < out_cycles.size(); i++) begin
            for (int j = i; j < out_cycles.size(); j++) begin
                span  = out_cycles[j] - out_cycles[i] + 1;
                limit = span * int'(cfg.num) / int'(cfg.denom) + 2;
                if (j - i + 1 > limit) begin
                    report_failure($sformatf(
                        "mismatch at time %0t: %0d beats in %0d cycles, limit %0d",
                        $time, j - i + 1, span, limit));
                end
            end
        end
    endtask

    // reset, send n_frames random frames, drain, check the counters
    task automatic run_phase(input rate_cfg_t c, input bit rand_ready, input bit win_chk,
                             input bit burst_chk, input int n_frames);
        int           beats;
        int           exp_bytes;
        int           len;
        logic [31:0]  seed;
        stream_beat_t b;
        beats     = 0;
        exp_bytes = 0;
        // link idle here, queues and sink mode are free to change
        @(posedge clk);
        ready_random = rand_ready;
        for (int f = 0; f < n_frames; f++) begin
            rng_state = xorshift(rng_state);
            len       = int'(rng_state[2:0]) + 1;
            rng_state = xorshift(rng_state);
            seed      = rng_state;
            for (int i = 0; i < len; i++) begin
                b = ref_beat(seed, len, i);
                drive_q.push_back(b);
                exp_q.push_back(b);
                exp_bytes += keep_bytes(b.keep);
                beats++;
            end
        end
        #2;
        cfg          = c;
        window_check = win_chk;
        burst_check  = burst_chk;
        out_cycles.delete();
        // slowest rate, four times over, plus slack
        deadline     = cycle_count + beats * int'(c.denom) * 4 / int'(c.num) + 1000;
        rst          = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        check_flag("m_valid", m_valid, 1'b0);
        check_flag("s_ready", s_ready, 1'b0);
        check_counts(frame_count, byte_count, 32'd0, 32'd0);
        rst = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // quiet tail, any extra beat shows up here
        repeat (8) @(posedge clk);
        #2;
        check_counts(frame_count, byte_count, n_frames, exp_bytes);
        if (win_chk) begin
            check_window();
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        cfg          = make_cfg(1, 1, 1'b0);
        s_beat       = '0;
        s_valid      = 1'b0;
        m_ready      = 1'b0;
        rng_state    = 32'd46033;
        ready_random = 1'b0;
        window_check = 1'b0;
        burst_check  = 1'b0;
        in_burst     = 1'b0;
        cycle_count  = 0;
        deadline     = 2000;
        // full rate, ready sink
        run_phase(make_cfg(1, 1, 1'b0), 1'b0, 1'b0, 1'b0, 12);
        // quarter rate per beat, window bound
        run_phase(make_cfg(1, 4, 1'b0), 1'b0, 1'b1, 1'b0, 12);
        // quarter rate per frame, frames unbroken
        run_phase(make_cfg(1, 4, 1'b1), 1'b0, 1'b0, 1'b1, 12);
        // random back-pressure under each rate
        run_phase(make_cfg(1, 1, 1'b0), 1'b1, 1'b0, 1'b0, 16);
        run_phase(make_cfg(1, 4, 1'b0), 1'b1, 1'b0, 1'b0, 16);
        run_phase(make_cfg(1, 4, 1'b1), 1'b1, 1'b0, 1'b0, 12);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
src/stream_pkg.sv
src/rate_pkg.sv
src/stream_fifo.sv
src/rate_limiter.sv
src/stream_stats.sv
src/rate_limited_port.sv
test/tb_rate_limited_port.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_rate_limited_port
RTL_TOP    = rate_limited_port
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
